/* all.f */
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/unaligned_ctrl_pkg.sv
hdl/lane_merge.sv
hdl/word_ram.sv
hdl/unaligned_fsm.sv
hdl/unaligned_mem_top.sv
dv/unaligned_mem_sva.sv
dv/unaligned_mem_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module unaligned_mem_tb \
    -f all.f -o unaligned_mem_sim

./obj_dir/unaligned_mem_sim +verilator+error+limit+100 | tee sim.log

if grep -q "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed, see sim.log"
    exit 1
fi

/* dv/unaligned_mem_tb.sv */
`timescale 1ns/1ns
`include "mem_defs.svh"

module unaligned_mem_tb;
    import mem_types_pkg::*;
    import unaligned_ctrl_pkg::*;

    localparam int clk_period   = 4;
    localparam int reset_cycles = 10;
    localparam int model_bytes  = `MEM_WORDS * `MEM_BYTES;
    localparam int n_random     = 200;
    // fill, aligned, unaligned reads, partial, unaligned writes, random, busy
    localparam int n_accesses   = `MEM_WORDS + 4 + 3 + 6 + 15 + n_random + 5;
    // cycles one access may take before it counts as hung
    localparam int access_limit = 20;

    typedef logic [$clog2(model_bytes)-1:0] bidx_t;

    logic       clk;
    logic       rst_n;
    logic       start;
    mem_req_t   req;
    logic       ready;
    word_t      rdata;
    logic       rdata_valid;

    // byte-array model of the RAM indexed by address modulo its size
    logic [7:0]  model [model_bytes];
    logic [15:0] lfsr;
    int          errors;
    int          err_at_start;
    int          tests_run;
    int          tests_failed;

    unaligned_mem_top u_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .req         (req),
        .ready       (ready),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    bind unaligned_fsm unaligned_mem_sva u_sva (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .ready       (ready),
        .ram_start   (ram_cmd.start),
        .ram_ready   (ram_ready),
        .rdata_valid (rdata_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // watchdog sized from the access count plus reset and margin
    initial begin
        #((n_accesses * 12 + reset_cycles + 200) * clk_period);
        $display("watchdog expired, the tests did not finish in time");
        $display("FAIL: see errors above");
        $finish;
    end

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one LFSR step per bit taken
    task automatic rand_bits(input int n, output word_t v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // little endian with byte a+i as data byte i
    function automatic word_t expected_word(input addr_t a);
        word_t w;
        for (int i = 0; i < `MEM_BYTES; i++) begin
            w[8*i +: 8] = model[bidx_t'(a + addr_t'(i))];
        end
        return w;
    endfunction

    task automatic update_model(input addr_t a, input word_t d, input mask_t m);
        bidx_t bi;
        for (int i = 0; i < `MEM_BYTES; i++) begin
            bi = bidx_t'(a + addr_t'(i));
            model[bi] = (model[bi] & ~m[8*i +: 8]) | (d[8*i +: 8] & m[8*i +: 8]);
        end
    endtask

    // launch one request and follow it until ready is back
    // poke pulses start with a clashing write to the next word while busy
    task automatic run_access(input mem_req_t r, input bit poke, output word_t got,
                              output int pulses);
        int       n;
        mem_req_t bogus;
        n      = 0;
        pulses = 0;
        got    = '0;
        bogus  = '{write: 1'b1, addr: r.addr + addr_t'(4), wdata: ~r.wdata, wmask: '1};
        while (!ready) begin
            @(posedge clk);
            #1;
            n++;
            if (n > access_limit) begin
                $display("ready never came back before a request to %h", r.addr);
                errors++;
                return;
            end
        end
        start = 1'b1;
        req   = r;
        @(posedge clk);
        #1;
        start = 1'b0;
        n     = 0;
        // count rdata_valid pulses until ready is back
        while (!ready) begin
            if (rdata_valid) begin
                pulses++;
                got = rdata;
            end
            if (poke) begin
                start = 1'b1;
                req   = bogus;
            end
            @(posedge clk);
            #1;
            start = 1'b0;
            n++;
            if (n > access_limit) begin
                $display("access to %h did not finish within %0d cycles", r.addr, n);
                errors++;
                return;
            end
        end
    endtask

    task automatic do_write(input addr_t a, input word_t d, input mask_t m,
                            input bit poke = 1'b0);
        word_t got;
        int    pulses;
        run_access('{write: 1'b1, addr: a, wdata: d, wmask: m}, poke, got, pulses);
        assert (pulses == 0) else begin
            $display("write to %h raised rdata_valid %0d times", a, pulses);
            errors++;
        end
        update_model(a, d, m);
    endtask

    task automatic do_read(input addr_t a, input word_t exp, input bit poke = 1'b0);
        word_t got;
        int    pulses;
        run_access('{write: 1'b0, addr: a, wdata: '0, wmask: '0}, poke, got, pulses);
        assert (pulses == 1) else begin
            $display("read at %h gave %0d rdata_valid pulses instead of one", a, pulses);
            errors++;
        end
        assert (got === exp) else begin
            $display("[ERROR] %0t rdata: got %h expected %h (addr %h)", $time, got, exp, a);
            errors++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == err_at_start) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - err_at_start);
        end
        err_at_start = errors;
    endtask

    // every word gets a value that depends on its whole index
    task automatic fill_memory();
        for (int w = 0; w < `MEM_WORDS; w++) begin
            do_write(addr_t'(w) << 2, word_t'(32'h9e37_79b9 * (w + 1)), '1);
        end
        finish_test("fill_memory");
    endtask

    task automatic aligned_full_rw();
        do_write(addr_t'(0), 32'hcafe_bebe, '1);
        do_write(addr_t'(4), 32'hdead_beef, '1);
        do_read(addr_t'(0), 32'hcafe_bebe);
        do_read(addr_t'(4), 32'hdead_beef);
        finish_test("aligned_full");
    endtask

    // bytes 0..7 are be be fe ca ef be ad de
    task automatic unaligned_reads();
        do_read(addr_t'(1), 32'hefca_febe);
        do_read(addr_t'(2), 32'hbeef_cafe);
        do_read(addr_t'(3), 32'hadbe_efca);
        finish_test("unaligned_reads");
    endtask

    task automatic partial_writes();
        word_t d;
        rand_bits(32, d);
        do_write(addr_t'(16), 32'h1122_3344, 32'h00ff_00ff);
        // bit granular masks
        do_write(addr_t'(20), d, 32'h0f0f_a5a5);
        do_write(addr_t'(24), ~d, 32'h8000_0001);
        do_read(addr_t'(16), expected_word(addr_t'(16)));
        do_read(addr_t'(20), expected_word(addr_t'(20)));
        do_read(addr_t'(24), expected_word(addr_t'(24)));
        finish_test("partial_writes");
    endtask

    task automatic unaligned_writes();
        addr_t addrs [5] = '{33, 42, 51, 1023, 32'h0001_03fe};
        mask_t masks [5] = '{32'hffff_ffff, 32'h00ff_ff00, 32'h0f0f_0f0f,
                             32'hffff_00ff, 32'h3c5a_a5c3};
        word_t d;
        addr_t base;
        for (int i = 0; i < 5; i++) begin
            rand_bits(32, d);
            do_write(addrs[i], d, masks[i]);
            base = addrs[i] & ~addr_t'(3);
            // read back both touched words and the top word wraps to word 0
            do_read(base, expected_word(base));
            do_read(base + addr_t'(4), expected_word(base + addr_t'(4)));
        end
        finish_test("unaligned_writes");
    endtask

    task automatic random_traffic();
        word_t a;
        word_t dir;
        word_t d;
        word_t mode;
        word_t bmask;
        mask_t m;
        for (int k = 0; k < n_random; k++) begin
            rand_bits(32, a);
            rand_bits(1, dir);
            if (dir[0]) begin
                rand_bits(32, d);
                rand_bits(2, mode);
                case (mode[1:0])
                    2'd0: m = '1;
                    2'd1: begin
                        rand_bits(4, bmask);
                        for (int i = 0; i < `MEM_BYTES; i++) begin
                            m[8*i +: 8] = {8{bmask[i]}};
                        end
                    end
                    default: rand_bits(32, m);
                endcase
                do_write(a, d, m);
            end else begin
                do_read(a, expected_word(a));
            end
        end
        finish_test("random_traffic");
    endtask

    // stray starts while busy must neither launch nor corrupt anything
    task automatic busy_starts();
        word_t d;
        rand_bits(32, d);
        do_read(addr_t'(41), expected_word(addr_t'(41)), 1'b1);
        do_read(addr_t'(41), expected_word(addr_t'(41)));
        do_write(addr_t'(63), d, 32'hff0f_f0ff, 1'b1);
        do_read(addr_t'(60), expected_word(addr_t'(60)));
        do_read(addr_t'(64), expected_word(addr_t'(64)));
        finish_test("busy");
    endtask

    initial begin
        rst_n        = 1'b0;
        start        = 1'b0;
        req          = '0;
        lfsr         = 16'd9472;
        errors       = 0;
        err_at_start = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst_n = 1'b1;
        fill_memory();
        aligned_full_rw();
        unaligned_reads();
        partial_writes();
        unaligned_writes();
        random_traffic();
        busy_starts();
        assert (u_dut.u_fsm.u_sva.fail_count == 0) else begin
            $display("handshake assertions failed %0d times", u_dut.u_fsm.u_sva.fail_count);
            errors++;
        end
        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* dv/unaligned_mem_sva.sv */
`timescale 1ns/1ns

module unaligned_mem_sva (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic ready,
    input logic ram_start,
    input logic ram_ready,
    input logic rdata_valid
);
    // failed assertions so far
    int unsigned fail_count = 0;

    // an accepted request leaves idle on the very next edge
    a_ready_drops: assert property (@(posedge clk) disable iff (!rst_n)
        (start && ready) |=> !ready)
        else begin
            fail_count++;
            $error("ready still high the cycle after an accepted start");
        end

    // RAM start only while the RAM can take it
    a_ram_start_ready: assert property (@(posedge clk) disable iff (!rst_n)
        ram_start |-> ram_ready)
        else begin
            fail_count++;
            $error("RAM start raised while ram_ready is low");
        end

    // response is a single-cycle pulse
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |=> !rdata_valid)
        else begin
            fail_count++;
            $error("rdata_valid high for two cycles in a row");
        end

    // response only while an access is in flight
    a_valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
        rdata_valid |-> !ready)
        else begin
            fail_count++;
            $error("rdata_valid high while ready is high");
        end

endmodule

/* hdl/unaligned_mem_top.sv */
`timescale 1ns/1ns

module unaligned_mem_top (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  unaligned_ctrl_pkg::mem_req_t req,
    output logic                        ready,
    output mem_types_pkg::word_t         rdata,
    output logic                        rdata_valid
);
    import mem_types_pkg::*;
    import unaligned_ctrl_pkg::*;

    // fsm <-> RAM
    ram_cmd_t   ram_cmd;
    logic       ram_ready;
    word_t      ram_rdata;
    logic       ram_rvalid;

    // fsm <-> lane merge
    mem_req_t   cap_req;
    word_t      rd_lo;
    word_t      rd_hi;
    merge_sel_e merge_sel;
    word_t      merged_wdata;

    unaligned_fsm u_fsm (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .req          (req),
        .ready        (ready),
        .rdata_valid  (rdata_valid),
        .ram_cmd      (ram_cmd),
        .ram_ready    (ram_ready),
        .ram_rdata    (ram_rdata),
        .ram_rvalid   (ram_rvalid),
        .cap_req      (cap_req),
        .rd_lo        (rd_lo),
        .rd_hi        (rd_hi),
        .merge_sel    (merge_sel),
        .merged_wdata (merged_wdata)
    );

    lane_merge u_merge (
        .cap_req      (cap_req),
        .rd_lo        (rd_lo),
        .rd_hi        (rd_hi),
        .merge_sel    (merge_sel),
        .ram_rdata    (ram_rdata),
        .merged_wdata (merged_wdata),
        .rdata        (rdata)
    );

    word_ram u_ram (
        .clk        (clk),
        .rst_n      (rst_n),
        .ram_cmd    (ram_cmd),
        .ram_ready  (ram_ready),
        .ram_rdata  (ram_rdata),
        .ram_rvalid (ram_rvalid)
    );

endmodule

/* hdl/unaligned_fsm.sv */
`timescale 1ns/1ns

module unaligned_fsm (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  unaligned_ctrl_pkg::mem_req_t   req,
    output logic                          ready,
    output logic                          rdata_valid,
    output unaligned_ctrl_pkg::ram_cmd_t   ram_cmd,
    input  logic                          ram_ready,
    input  mem_types_pkg::word_t           ram_rdata,
    input  logic                          ram_rvalid,
    output unaligned_ctrl_pkg::mem_req_t   cap_req,
    output mem_types_pkg::word_t           rd_lo,
    output mem_types_pkg::word_t           rd_hi,
    output unaligned_ctrl_pkg::merge_sel_e merge_sel,
    input  mem_types_pkg::word_t           merged_wdata
);
    import mem_types_pkg::*;
    import unaligned_ctrl_pkg::*;

    ctrl_state_e state;
    logic [1:0]  offset;
    logic        full_mask;
    logic        direct_write;
    widx_t       idx;
    widx_t       idx_next;

    // byte offset inside the word picks the one- or two-word path
    assign offset       = cap_req.addr[1:0];
    assign full_mask    = (cap_req.wmask == '1);
    // aligned full-mask write goes straight to the RAM, no read first
    assign direct_write = cap_req.write && (offset == 2'd0) && full_mask;

    // word index of the addressed word and of its neighbour
    // the neighbour wraps from the last word to word 0
    assign idx      = widx_t'(cap_req.addr >> 2);
    assign idx_next = idx + widx_t'(1);

    assign ready = (state == idle);

    // response valid only on the last read return of a read access
    assign rdata_valid = ram_rvalid &&
                         ((state == wait_rd_valid && offset == 2'd0) ||
                          state == wait_next_valid);

    // RAM command, start only raised while the RAM is ready
    always_comb begin
        ram_cmd.start = 1'b0;
        ram_cmd.write = 1'b0;
        ram_cmd.waddr = idx;
        // merged word covers the direct write too, its mask is all ones
        ram_cmd.wdata = merged_wdata;
        merge_sel     = merge_full;
        case (state)
            wait_ready: begin
                ram_cmd.start = ram_ready;
                ram_cmd.write = direct_write;
            end
            wait_wr_ready: begin
                ram_cmd.start = ram_ready;
                ram_cmd.write = 1'b1;
            end
            wait_next_ready_before_wr, wait_next_ready: begin
                ram_cmd.start = ram_ready;
                ram_cmd.waddr = idx_next;
            end
            wait_wr_lo: begin
                ram_cmd.start = ram_ready;
                ram_cmd.write = 1'b1;
                merge_sel     = merge_lo;
            end
            wait_wr_hi: begin
                ram_cmd.start = ram_ready;
                ram_cmd.write = 1'b1;
                ram_cmd.waddr = idx_next;
                merge_sel     = merge_hi;
            end
            default: begin
                ram_cmd.start = 1'b0;
            end
        endcase
    end

    // request capture and read words
    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            cap_req <= req;
        end
        // first read return is always the low word
        if (ram_rvalid && (state == rd_before_wr || state == wait_rd_valid)) begin
            rd_lo <= ram_rdata;
        end
        if (ram_rvalid && state == wait_next_valid_before_wr) begin
            rd_hi <= ram_rdata;
        end
    end

    // state sequencing
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (start) state <= wait_ready;
                end
                wait_ready: begin
                    if (ram_ready) begin
                        if (!cap_req.write) state <= wait_rd_valid;
                        else if (direct_write) state <= done;
                        else state <= rd_before_wr;
                    end
                end
                rd_before_wr: begin
                    if (ram_rvalid) begin
                        if (offset == 2'd0) state <= wait_wr_ready;
                        else state <= wait_next_ready_before_wr;
                    end
                end
                wait_wr_ready: begin
                    if (ram_ready) state <= done;
                end
                wait_next_ready_before_wr: begin
                    if (ram_ready) state <= wait_next_valid_before_wr;
                end
                wait_next_valid_before_wr: begin
                    if (ram_rvalid) state <= wait_wr_lo;
                end
                // merge writes wait on RAM ready
                wait_wr_lo: begin
                    if (ram_ready) state <= wait_wr_hi;
                end
                wait_wr_hi: begin
                    if (ram_ready) state <= done;
                end
                wait_rd_valid: begin
                    if (ram_rvalid) begin
                        if (offset == 2'd0) state <= done;
                        else state <= wait_next_ready;
                    end
                end
                wait_next_ready: begin
                    if (ram_ready) state <= wait_next_valid;
                end
                wait_next_valid: begin
                    if (ram_rvalid) state <= done;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

endmodule

/* hdl/word_ram.sv */
`timescale 1ns/1ns
`include "mem_defs.svh"

module word_ram (
    input  logic                        clk,
    input  logic                        rst_n,
    input  unaligned_ctrl_pkg::ram_cmd_t ram_cmd,
    output logic                        ram_ready,
    output mem_types_pkg::word_t         ram_rdata,
    output logic                        ram_rvalid
);
    import mem_types_pkg::*;

    word_t mem [`MEM_WORDS];
    logic  fire;
    logic  rd_fire;

    // command taken when start meets ready
    assign fire    = ram_cmd.start && ram_ready;
    assign rd_fire = fire && !ram_cmd.write;

    // busy for the cycle the read data is out
    assign ram_ready = !ram_rvalid;

    // storage and registered read port
    always_ff @(posedge clk) begin
        if (fire && ram_cmd.write) begin
            mem[ram_cmd.waddr] <= ram_cmd.wdata;
        end
        if (rd_fire) begin
            ram_rdata <= mem[ram_cmd.waddr];
        end
    end

    // read valid is the read command one cycle later
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ram_rvalid <= 1'b0;
        end else begin
            ram_rvalid <= rd_fire;
        end
    end

endmodule

/* hdl/lane_merge.sv */
`timescale 1ns/1ns
`include "mem_defs.svh"

module lane_merge (
    input  unaligned_ctrl_pkg::mem_req_t   cap_req,
    input  mem_types_pkg::word_t           rd_lo,
    input  mem_types_pkg::word_t           rd_hi,
    input  unaligned_ctrl_pkg::merge_sel_e merge_sel,
    input  mem_types_pkg::word_t           ram_rdata,
    output mem_types_pkg::word_t           merged_wdata,
    output mem_types_pkg::word_t           rdata
);
    import mem_types_pkg::*;
    import unaligned_ctrl_pkg::*;

    logic [1:0]                offset;
    logic [4:0]                shamt;
    logic [2*`MEM_DATA_W-1:0] data_wide;
    logic [2*`MEM_DATA_W-1:0] mask_wide;
    logic [2*`MEM_DATA_W-1:0] read_wide;
    word_t                     old_word;
    word_t                     new_data;
    mask_t                     new_mask;

    assign offset = cap_req.addr[1:0];
    // bit shift for the byte offset, 0/8/16/24
    assign shamt  = {offset, 3'b000};

    // request data and mask placed across the two-word window
    // byte i of the request lands at window byte offset+i
    assign data_wide = {{`MEM_DATA_W{1'b0}}, cap_req.wdata} << shamt;
    assign mask_wide = {{`MEM_DATA_W{1'b0}}, cap_req.wmask} << shamt;

    always_comb begin
        case (merge_sel)
            merge_lo: begin
                old_word = rd_lo;
                new_data = data_wide[`MEM_DATA_W-1:0];
                new_mask = mask_wide[`MEM_DATA_W-1:0];
            end
            merge_hi: begin
                // spill-over part lands in the low bytes of the next word
                old_word = rd_hi;
                new_data = data_wide[2*`MEM_DATA_W-1:`MEM_DATA_W];
                new_mask = mask_wide[2*`MEM_DATA_W-1:`MEM_DATA_W];
            end
            default: begin
                // aligned: plain masked blend
                old_word = rd_lo;
                new_data = cap_req.wdata;
                new_mask = cap_req.wmask;
            end
        endcase
    end

    // untouched bits keep the old word
    assign merged_wdata = (old_word & ~new_mask) | (new_data & new_mask);

    // read window, upper bytes of the low word then lower bytes of live RAM word
    assign read_wide = {ram_rdata, rd_lo} >> shamt;
    assign rdata     = (offset == 2'd0) ? ram_rdata : read_wide[`MEM_DATA_W-1:0];

endmodule

/* hdl/unaligned_ctrl_pkg.sv */
package unaligned_ctrl_pkg;
    import mem_types_pkg::*;

    // controller states for the read, read-modify-write and direct write walks
    typedef enum logic [3:0] {
        idle, wait_ready, done,
        rd_before_wr, wait_wr_ready,
        wait_next_ready_before_wr, wait_next_valid_before_wr,
        wait_wr_lo, wait_wr_hi,
        wait_rd_valid, wait_next_ready, wait_next_valid
    } ctrl_state_e;

    // which word lane_merge builds for the next write
    typedef enum logic [1:0] {merge_full, merge_lo, merge_hi} merge_sel_e;

    // request as seen on the top ports and as captured
    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
        mask_t wmask;
    } mem_req_t;

    // aligned command towards the word RAM
    typedef struct packed {
        logic  start;
        logic  write;
        widx_t waddr;
        word_t wdata;
    } ram_cmd_t;

endpackage

/* hdl/mem_types_pkg.sv */
`include "mem_defs.svh"

package mem_types_pkg;

    // one data word, little-endian byte lanes
    typedef logic [`MEM_DATA_W-1:0] word_t;

    // byte address of a request
    typedef logic [`MEM_ADDR_W-1:0] addr_t;

    // bitwise write mask, bit i enables data bit i
    typedef logic [`MEM_DATA_W-1:0] mask_t;

    // word index into the RAM
    typedef logic [$clog2(`MEM_WORDS)-1:0] widx_t;

endpackage

/* hdl/mem_defs.svh */
`ifndef MEM_DEFS_SVH
`define MEM_DEFS_SVH

// width of one RAM word and of the request data
`define MEM_DATA_W 32

// byte address width on the request side
`define MEM_ADDR_W 32

// depth of the backing RAM in words
// word index = (address / 4) mod depth, so the index
// wraps past the last word back to word 0
`define MEM_WORDS 256

// byte lanes per word
`define MEM_BYTES (`MEM_DATA_W / 8)

`endif
